// ==== src/ex_types_pkg.sv ====
//**********************************************************
// scalar execute stage definitions shared by all RTL files
// alu_op_t and branch_type_t leave upper codes unused
// mul_op_t covers MUL and MULHU only, no division
//**********************************************************
package ex_types_pkg;

    // shift-add steps for one multiply
    localparam int MUL_CYCLES = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    typedef enum logic [1:0] {ASEL_RS1, ASEL_IMM_S, ASEL_PC, ASEL_ZERO} a_sel_t;
    typedef enum logic [1:0] {BSEL_RS1, BSEL_RS2, BSEL_IMM_I, BSEL_IMM_U} b_sel_t;

    typedef enum logic [2:0] {
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU
    } branch_type_t;

    typedef enum logic {MUL_LO, MUL_HU} mul_op_t;

endpackage

// ==== src/vcfg_pkg.sv ====
//**********************************************************
// vector configuration definitions for vsetvl handling
// sew above 32 bits and lmul code 4 are not supported
//**********************************************************
package vcfg_pkg;

    // register length in bytes, 128-bit vectors
    localparam int VLEN_BYTES = 16;

    typedef enum logic [2:0] {SEW8 = 3'd0, SEW16 = 3'd1, SEW32 = 3'd2} vsew_t;

    // code 4 is reserved
    typedef enum logic [2:0] {
        LMUL1      = 3'd0,
        LMUL2      = 3'd1,
        LMUL4      = 3'd2,
        LMUL8      = 3'd3,
        LMULEIGHTH = 3'd5,
        LMULFOURTH = 3'd6,
        LMULHALF   = 3'd7
    } vlmul_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vset_kind_t;

    typedef struct packed {
        logic        vill;
        logic [22:0] reserved;
        logic        vma;
        logic        vta;
        vsew_t       vsew;
        vlmul_t      vlmul;
    } vtype_fields_t;

    // one vtype word, seen as a raw register value or as fields
    typedef union packed {
        logic [31:0]   raw;
        vtype_fields_t f;
    } vtype_u;

endpackage

// ==== src/scalar_reg_file.sv ====
//**********************************************************
// 32 x 32 scalar register file, x0 hardwired to zero
// reads are combinational, a write is seen the next cycle
//**********************************************************
`timescale 1ns/10ps

module scalar_reg_file
    import ex_types_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wen,
    input  reg_idx_t rd,
    input  word_t    w_data
);

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= w_data;
        end
    end

    // no bypass from the write port
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== src/operand_alu.sv ====
//**********************************************************
// operand select and integer ALU, purely combinational
// shifts use port_b[4:0], imm_u arrives already shifted
//**********************************************************
`timescale 1ns/10ps

module operand_alu
    import ex_types_pkg::*;
(
    input  word_t       pc,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  logic [11:0] imm_i,
    input  logic [11:0] imm_s,
    input  word_t       imm_u,
    input  a_sel_t      a_sel,
    input  b_sel_t      b_sel,
    input  alu_op_t     alu_op,
    output word_t       port_a,
    output word_t       port_b,
    output word_t       alu_out
);

    word_t      imm_i_ext;
    word_t      imm_s_ext;
    logic [4:0] shamt;

    assign imm_i_ext = {{20{imm_i[11]}}, imm_i};
    assign imm_s_ext = {{20{imm_s[11]}}, imm_s};

    // port a: rs1, store offset, pc or zero
    always_comb begin
        case (a_sel)
            ASEL_RS1:   port_a = rs1_data;
            ASEL_IMM_S: port_a = imm_s_ext;
            ASEL_PC:    port_a = pc;
            default:    port_a = '0;
        endcase
    end

    // port b: rs1 again for some reg-only ops
    always_comb begin
        case (b_sel)
            BSEL_RS1:   port_b = rs1_data;
            BSEL_RS2:   port_b = rs2_data;
            BSEL_IMM_I: port_b = imm_i_ext;
            default:    port_b = imm_u;
        endcase
    end

    assign shamt = port_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = port_a + port_b;
            ALU_SUB:  alu_out = port_a - port_b;
            ALU_AND:  alu_out = port_a & port_b;
            ALU_OR:   alu_out = port_a | port_b;
            ALU_XOR:  alu_out = port_a ^ port_b;
            ALU_SLL:  alu_out = port_a << shamt;
            ALU_SRL:  alu_out = port_a >> shamt;
            ALU_SRA:  alu_out = $signed(port_a) >>> shamt;
            ALU_SLT:  alu_out = {31'b0, $signed(port_a) < $signed(port_b)};
            ALU_SLTU: alu_out = {31'b0, port_a < port_b};
            // unused op codes give zero
            default:  alu_out = '0;
        endcase
    end

endmodule

// ==== src/branch_jump_unit.sv ====
//**********************************************************
// branch compare and branch/jump target resolution
// jalr clears bit 0, no misaligned target check is made
//**********************************************************
`timescale 1ns/10ps

module branch_jump_unit
    import ex_types_pkg::*;
(
    input  word_t        pc,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    input  logic [11:0]  imm_i,
    input  logic [12:0]  imm_sb,
    input  logic [20:0]  imm_uj,
    input  branch_type_t branch_type,
    input  logic         is_branch,
    input  logic         is_jump,
    input  logic         j_sel,
    output logic         branch_taken,
    output word_t        brj_addr
);

    logic  cmp;
    word_t imm_i_ext;
    word_t imm_sb_ext;
    word_t imm_uj_ext;
    word_t jump_addr;

    assign imm_i_ext  = {{20{imm_i[11]}}, imm_i};
    assign imm_sb_ext = {{19{imm_sb[12]}}, imm_sb};
    assign imm_uj_ext = {{11{imm_uj[20]}}, imm_uj};

    always_comb begin
        case (branch_type)
            BR_BEQ:  cmp = (rs1_data == rs2_data);
            BR_BNE:  cmp = (rs1_data != rs2_data);
            BR_BLT:  cmp = ($signed(rs1_data) < $signed(rs2_data));
            BR_BGE:  cmp = ($signed(rs1_data) >= $signed(rs2_data));
            BR_BLTU: cmp = (rs1_data < rs2_data);
            BR_BGEU: cmp = (rs1_data >= rs2_data);
            default: cmp = 1'b0;
        endcase
    end

    assign branch_taken = is_branch && cmp;

    // jal is pc relative, jalr is rs1 relative
    assign jump_addr = j_sel ? (pc + imm_uj_ext) : ((rs1_data + imm_i_ext) & ~32'd1);

    // fall through to pc + 4 for anything not taken
    assign brj_addr = is_jump      ? jump_addr :
                      branch_taken ? (pc + imm_sb_ext) : (pc + 32'd4);

endmodule

// ==== src/iter_multiplier.sv ====
//**********************************************************
// iterative shift-add multiplier for MUL and MULHU only
// done rises MUL_CYCLES edges after start and holds to ack
// start must not come while busy or done is pending
//**********************************************************
`timescale 1ns/10ps

module iter_multiplier
    import ex_types_pkg::*;
(
    input  logic    CLK,
    input  logic    nRST,
    input  logic    start,
    input  mul_op_t op,
    input  word_t   a,
    input  word_t   b,
    output logic    done,
    output word_t   product,
    input  logic    ack
);

    logic        busy;
    logic [4:0]  step;
    mul_op_t     op_q;
    logic [63:0] mcand;
    word_t       mplier;
    logic [63:0] acc;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            step <= '0;
        end else if (busy) begin
            step <= step + 5'd1;
            // last partial product lands on this edge
            if (step == 5'(MUL_CYCLES - 1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    // one multiplier bit per cycle from the lsb up
    always_ff @(posedge CLK) begin
        if (start) begin
            op_q   <= op;
            mcand  <= {32'b0, a};
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // mulhu is just the high word as both operands are unsigned
    assign product = (op_q == MUL_HU) ? acc[63:32] : acc[31:0];

    assert property (@(posedge CLK) disable iff (!nRST) start |-> !busy && !done);

endmodule

// ==== src/vsetvl_unit.sv ====
//**********************************************************
// vsetvl/vsetvli/vsetivli vl and vtype computation
// an illegal vtype returns vill alone and a vl of zero
// outputs are meaningless when vset_kind is NOT_CFG
//**********************************************************
`timescale 1ns/10ps

module vsetvl_unit
    import ex_types_pkg::*;
    import vcfg_pkg::*;
(
    input  vset_kind_t  vset_kind,
    input  reg_idx_t    rs1_idx,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  logic [4:0]  zimm,
    input  logic [10:0] vtype_imm,
    output word_t       new_vl,
    output vtype_u      new_vtype
);

    vtype_u req;
    word_t  base;
    word_t  vlmax;
    word_t  avl;
    logic   illegal;

    // vsetvl takes vtype from rs2, the immediate forms from the instruction
    assign req.raw = (vset_kind == VSETVL) ? rs2_data : {21'b0, vtype_imm};

    assign illegal = (req.f.vsew > SEW32) || (req.f.vlmul == 3'd4) ||
                     (req.f.reserved != '0) || req.f.vill;

    // elements per register at this sew
    assign base = word_t'(VLEN_BYTES) >> req.f.vsew;

    always_comb begin
        case (req.f.vlmul)
            LMUL1:      vlmax = base;
            LMUL2:      vlmax = base << 1;
            LMUL4:      vlmax = base << 2;
            LMUL8:      vlmax = base << 3;
            LMULHALF:   vlmax = base >> 1;
            LMULFOURTH: vlmax = base >> 2;
            LMULEIGHTH: vlmax = base >> 3;
            default:    vlmax = '0;
        endcase
    end

    // rs1 = x0 asks for the largest vl
    assign avl = (vset_kind == VSETIVLI) ? {27'b0, zimm} :
                 (rs1_idx == '0)          ? vlmax : rs1_data;

    assign new_vl        = illegal ? '0 : ((avl > vlmax) ? vlmax : avl);
    assign new_vtype.raw = illegal ? {1'b1, 31'b0} : req.raw;

endmodule

// ==== src/execute_stage.sv ====
//**********************************************************
// execute stage top with one output register
// valid/ready on issue and result, one item in flight
// no forwarding, issue only after dependent writes retire
//**********************************************************
`timescale 1ns/10ps

module execute_stage
    import ex_types_pkg::*;
    import vcfg_pkg::*;
(
    input  logic         CLK,
    input  logic         nRST,
    input  logic         in_valid,
    output logic         in_ready,
    input  word_t        pc,
    input  alu_op_t      alu_op,
    input  a_sel_t       a_sel,
    input  b_sel_t       b_sel,
    input  reg_idx_t     rs1,
    input  reg_idx_t     rs2,
    input  reg_idx_t     rd,
    input  logic         reg_write,
    input  logic [11:0]  imm_i,
    input  logic [11:0]  imm_s,
    input  logic [12:0]  imm_sb,
    input  logic [20:0]  imm_uj,
    input  word_t        imm_u,
    input  logic [4:0]   zimm,
    input  logic         is_branch,
    input  logic         is_jump,
    input  logic         j_sel,
    input  branch_type_t branch_type,
    input  logic         mul_sel,
    input  mul_op_t      mul_op,
    input  vset_kind_t   vset_kind,
    input  logic [10:0]  vtype_imm,
    output logic         out_valid,
    input  logic         out_ready,
    output reg_idx_t     out_rd,
    output logic         out_reg_write,
    output word_t        out_result,
    output word_t        out_brj_addr,
    output logic         out_branch_taken,
    output word_t        out_vtype,
    input  logic         wb_en,
    input  reg_idx_t     wb_rd,
    input  word_t        wb_data
);

    word_t  rs1_data;
    word_t  rs2_data;
    word_t  port_a;
    word_t  port_b;
    word_t  alu_out;
    logic   branch_taken;
    word_t  brj_addr;
    logic   mul_done;
    word_t  mul_product;
    word_t  new_vl;
    vtype_u new_vtype;
    logic   is_vset;
    logic   accept;
    logic   mul_ack;
    logic   mul_pending;

    scalar_reg_file i_rf (
        .CLK, .nRST,
        .rs1, .rs2, .rs1_data, .rs2_data,
        .wen(wb_en), .rd(wb_rd), .w_data(wb_data)
    );

    operand_alu i_alu (
        .pc, .rs1_data, .rs2_data, .imm_i, .imm_s, .imm_u,
        .a_sel, .b_sel, .alu_op, .port_a, .port_b, .alu_out
    );

    branch_jump_unit i_bju (
        .pc, .rs1_data, .rs2_data, .imm_i, .imm_sb, .imm_uj,
        .branch_type, .is_branch, .is_jump, .j_sel, .branch_taken, .brj_addr
    );

    // multiplier shares the alu operand path
    iter_multiplier i_mul (
        .CLK, .nRST,
        .start(accept && mul_sel), .op(mul_op), .a(port_a), .b(port_b),
        .done(mul_done), .product(mul_product), .ack(mul_ack)
    );

    vsetvl_unit i_vset (
        .vset_kind, .rs1_idx(rs1), .rs1_data, .rs2_data,
        .zimm, .vtype_imm, .new_vl, .new_vtype
    );

    assign is_vset  = (vset_kind != NOT_CFG);
    assign in_ready = !mul_pending && (!out_valid || out_ready);
    assign accept   = in_valid && in_ready;
    // a finished product waits in the multiplier until the register frees
    assign mul_ack  = mul_done && (!out_valid || out_ready);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out_valid   <= 1'b0;
            mul_pending <= 1'b0;
        end else begin
            if ((accept && !mul_sel) || mul_ack) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            if (accept && mul_sel) begin
                mul_pending <= 1'b1;
            end else if (mul_ack) begin
                mul_pending <= 1'b0;
            end
        end
    end

    // side fields of a multiply load at issue, out_valid stays low until the product
    always_ff @(posedge CLK) begin
        if (accept) begin
            out_rd           <= rd;
            out_reg_write    <= reg_write;
            out_brj_addr     <= brj_addr;
            out_branch_taken <= branch_taken;
            out_vtype        <= is_vset ? new_vtype.raw : '0;
            out_result       <= is_vset ? new_vl : alu_out;
        end else if (mul_ack) begin
            out_result <= mul_product;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        out_valid && !out_ready |=> out_valid &&
            $stable({out_rd, out_reg_write, out_result, out_brj_addr,
                     out_branch_taken, out_vtype}));

endmodule

// ==== include/ex_ref_model.svh ====
//**********************************************************
// reference functions for the execute stage testbench
// operands are given as the bench sees them, no hazards
//**********************************************************
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

function automatic logic [31:0] ref_alu(
    input ex_types_pkg::alu_op_t op,
    input ex_types_pkg::a_sel_t  a_sel,
    input ex_types_pkg::b_sel_t  b_sel,
    input logic [31:0]           rs1v,
    input logic [31:0]           rs2v,
    input logic [31:0]           pc,
    input logic [11:0]           imm_i,
    input logic [11:0]           imm_s,
    input logic [31:0]           imm_u
);
    logic [31:0] a;
    logic [31:0] b;
    a = (a_sel == ex_types_pkg::ASEL_RS1)   ? rs1v :
        (a_sel == ex_types_pkg::ASEL_IMM_S) ? {{20{imm_s[11]}}, imm_s} :
        (a_sel == ex_types_pkg::ASEL_PC)    ? pc : 32'd0;
    b = (b_sel == ex_types_pkg::BSEL_RS1)   ? rs1v :
        (b_sel == ex_types_pkg::BSEL_RS2)   ? rs2v :
        (b_sel == ex_types_pkg::BSEL_IMM_I) ? {{20{imm_i[11]}}, imm_i} : imm_u;
    case (op)
        ex_types_pkg::ALU_ADD:  return a + b;
        ex_types_pkg::ALU_SUB:  return a - b;
        ex_types_pkg::ALU_AND:  return a & b;
        ex_types_pkg::ALU_OR:   return a | b;
        ex_types_pkg::ALU_XOR:  return a ^ b;
        ex_types_pkg::ALU_SLL:  return a << b[4:0];
        ex_types_pkg::ALU_SRL:  return a >> b[4:0];
        ex_types_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
        ex_types_pkg::ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
        ex_types_pkg::ALU_SLTU: return {31'b0, a < b};
        default:                return 32'd0;
    endcase
endfunction

function automatic void ref_branch(
    input  ex_types_pkg::branch_type_t bt,
    input  logic        is_branch,
    input  logic        is_jump,
    input  logic        j_sel,
    input  logic [31:0] pc,
    input  logic [31:0] rs1v,
    input  logic [31:0] rs2v,
    input  logic [11:0] imm_i,
    input  logic [12:0] imm_sb,
    input  logic [20:0] imm_uj,
    output logic        taken,
    output logic [31:0] addr
);
    logic c;
    case (bt)
        ex_types_pkg::BR_BEQ:  c = rs1v == rs2v;
        ex_types_pkg::BR_BNE:  c = rs1v != rs2v;
        ex_types_pkg::BR_BLT:  c = $signed(rs1v) < $signed(rs2v);
        ex_types_pkg::BR_BGE:  c = $signed(rs1v) >= $signed(rs2v);
        ex_types_pkg::BR_BLTU: c = rs1v < rs2v;
        ex_types_pkg::BR_BGEU: c = rs1v >= rs2v;
        default:               c = 1'b0;
    endcase
    taken = is_branch && c;
    if (is_jump) begin
        addr = j_sel ? pc + {{11{imm_uj[20]}}, imm_uj}
                     : (rs1v + {{20{imm_i[11]}}, imm_i}) & 32'hffff_fffe;
    end else begin
        addr = taken ? pc + {{19{imm_sb[12]}}, imm_sb} : pc + 32'd4;
    end
endfunction

function automatic logic [31:0] ref_mul(
    input ex_types_pkg::mul_op_t op,
    input logic [31:0]           a,
    input logic [31:0]           b
);
    logic [63:0] p;
    p = {32'b0, a} * {32'b0, b};
    return (op == ex_types_pkg::MUL_HU) ? p[63:32] : p[31:0];
endfunction

function automatic void ref_vsetvl(
    input  vcfg_pkg::vset_kind_t kind,
    input  logic [4:0]  rs1_idx,
    input  logic [31:0] rs1v,
    input  logic [31:0] rs2v,
    input  logic [4:0]  zimm,
    input  logic [10:0] vtype_imm,
    output logic [31:0] vl,
    output logic [31:0] vtype
);
    logic [31:0] req;
    logic [31:0] vlmax;
    logic [31:0] avl;
    req   = (kind == vcfg_pkg::VSETVL) ? rs2v : {21'b0, vtype_imm};
    vlmax = (vcfg_pkg::VLEN_BYTES << req[2:0]) >> req[5:3];
    if (req[2]) begin
        vlmax = vcfg_pkg::VLEN_BYTES >> (8 - req[2:0]) >> req[5:3];
    end
    avl = (kind == vcfg_pkg::VSETIVLI) ? {27'b0, zimm} : (rs1_idx == 5'd0) ? vlmax : rs1v;
    if (req[5:3] > 3'd2 || req[2:0] == 3'd4 || req[31:8] != 24'd0) begin
        vl    = 32'd0;
        vtype = 32'h8000_0000;
    end else begin
        vl    = (avl < vlmax) ? avl : vlmax;
        vtype = req;
    end
endfunction

`endif

// ==== tb/ex_tb.sv ====
//**********************************************************
// self-checking testbench for execute_stage
// expected values come from ex_ref_model.svh and a shadow
// copy of the register file kept from the writeback port
// ops issue only after the writes they read have retired
//**********************************************************
`timescale 1ns/10ps

module ex_tb
    import ex_types_pkg::*;
    import vcfg_pkg::*;
();

    localparam int N_ALU  = 60;
    localparam int N_BR   = 40;
    localparam int N_MUL  = 12;
    localparam int N_VSET = 68;
    localparam int N_RAND = 40;
    localparam int N_OPS  = N_ALU + N_BR + N_MUL + N_VSET + N_RAND;
    // a multiply plus its drain stays well below 40 cycles
    localparam int CYCLE_LIMIT = 40 * N_OPS + 200;

    // one result payload, same bit order as out_payload
    typedef logic [102:0] cmp_t;
    typedef struct packed {
        reg_idx_t rd;
        logic     reg_write;
        word_t    result;
        word_t    brj_addr;
        logic     taken;
        word_t    vtype;
    } exp_t;

    logic         CLK;
    logic         nRST;
    logic         in_valid;
    logic         in_ready;
    word_t        pc;
    alu_op_t      alu_op;
    a_sel_t       a_sel;
    b_sel_t       b_sel;
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    logic         reg_write;
    logic [11:0]  imm_i;
    logic [11:0]  imm_s;
    logic [12:0]  imm_sb;
    logic [20:0]  imm_uj;
    word_t        imm_u;
    logic [4:0]   zimm;
    logic         is_branch;
    logic         is_jump;
    logic         j_sel;
    branch_type_t branch_type;
    logic         mul_sel;
    mul_op_t      mul_op;
    vset_kind_t   vset_kind;
    logic [10:0]  vtype_imm;
    logic         out_valid;
    logic         out_ready;
    reg_idx_t     out_rd;
    logic         out_reg_write;
    word_t        out_result;
    word_t        out_brj_addr;
    logic         out_branch_taken;
    word_t        out_vtype;
    logic         wb_en;
    reg_idx_t     wb_rd;
    word_t        wb_data;

    int    seed = 48120;
    int    errors = 0;
    int    issued = 0;
    int    results_seen = 0;
    int    cycles = 0;
    logic  rand_ready = 1'b0;
    word_t shadow [32];
    exp_t  exp_q [$];
    exp_t  cur_exp;
    logic  held_valid = 1'b0;
    cmp_t  held_payload;
    cmp_t  out_payload;

    `include "ex_ref_model.svh"

    execute_stage i_dut (.*);

    assign out_payload = {out_rd, out_reg_write, out_result, out_brj_addr,
                          out_branch_taken, out_vtype};

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // back-pressure only in the random phase, else always ready
    always @(posedge CLK) begin
        #1;
        out_ready = rand_ready ? 1'($random(seed)) : 1'b1;
    end

    task automatic check_value(input string what, input cmp_t got, input cmp_t expected);
        if (got !== expected) begin
            $display("Mismatch at %0t: %s, got %0h expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic write_reg(input reg_idx_t idx, input word_t data);
        wb_en   = 1'b1;
        wb_rd   = idx;
        wb_data = data;
        @(posedge CLK);
        #1;
        wb_en = 1'b0;
        // x0 keeps reading zero
        if (idx != 5'd0) begin
            shadow[idx] = data;
        end
    endtask

    // plain ALU op with random fields, the other tasks adjust it
    task automatic base_payload();
        pc          = word_t'($random(seed)) & 32'hffff_fffc;
        alu_op      = ALU_ADD;
        a_sel       = ASEL_RS1;
        b_sel       = BSEL_RS2;
        rs1         = 5'($random(seed));
        rs2         = 5'($random(seed));
        rd          = 5'($random(seed));
        reg_write   = 1'($random(seed));
        imm_i       = 12'($random(seed));
        imm_s       = 12'($random(seed));
        imm_sb      = 13'($random(seed)) & 13'h1ffe;
        imm_uj      = 21'($random(seed)) & 21'h1f_fffe;
        imm_u       = word_t'($random(seed)) & 32'hffff_f000;
        zimm        = 5'($random(seed));
        is_branch   = 1'b0;
        is_jump     = 1'b0;
        j_sel       = 1'b0;
        branch_type = BR_BEQ;
        mul_sel     = 1'b0;
        mul_op      = MUL_LO;
        vset_kind   = NOT_CFG;
        vtype_imm   = '0;
    endtask

    task automatic make_alu_op(input logic use_x0);
        base_payload();
        alu_op = alu_op_t'(4'($unsigned($random(seed)) % 10));
        a_sel  = a_sel_t'(2'($random(seed)));
        b_sel  = b_sel_t'(2'($random(seed)));
        // x0 | x0 after a write to x0
        if (use_x0) begin
            rs1    = 5'd0;
            alu_op = ALU_OR;
            a_sel  = ASEL_RS1;
            b_sel  = BSEL_RS1;
        end
    endtask

    task automatic make_branch_op();
        base_payload();
        branch_type = branch_type_t'(3'($unsigned($random(seed)) % 6));
        is_branch   = 1'b1;
        // about one op in four is a jump, jal or jalr
        if (2'($random(seed)) == 2'd0) begin
            is_branch = 1'b0;
            is_jump   = 1'b1;
            j_sel     = 1'($random(seed));
        end
        // equal operands now and then
        if (2'($random(seed)) == 2'd0) begin
            rs2 = rs1;
        end
    endtask

    task automatic make_mul_op();
        base_payload();
        mul_sel = 1'b1;
        mul_op  = mul_op_t'(1'($random(seed)));
        a_sel   = ASEL_RS1;
        b_sel   = BSEL_RS2;
    endtask

    task automatic make_vset_op(input vset_kind_t kind, input reg_idx_t idx, input word_t vt);
        // vsetvl takes its vtype from x8
        if (kind == VSETVL) begin
            write_reg(5'd8, vt);
        end
        base_payload();
        vset_kind = kind;
        rs1       = idx;
        rs2       = 5'd8;
        vtype_imm = vt[10:0];
    endtask

    // expected record from the held payload, then the issue handshake
    task automatic send_op();
        exp_t  e;
        word_t rs1v;
        word_t rs2v;
        logic  taken;
        word_t addr;
        word_t vl;
        word_t vt;
        rs1v = shadow[rs1];
        rs2v = shadow[rs2];
        ref_branch(branch_type, is_branch, is_jump, j_sel, pc, rs1v, rs2v,
                   imm_i, imm_sb, imm_uj, taken, addr);
        ref_vsetvl(vset_kind, rs1, rs1v, rs2v, zimm, vtype_imm, vl, vt);
        e.rd        = rd;
        e.reg_write = reg_write;
        e.brj_addr  = addr;
        e.taken     = taken;
        e.vtype     = '0;
        if (mul_sel) begin
            // multiplies always take rs1 and rs2 here
            e.result = ref_mul(mul_op, rs1v, rs2v);
        end else if (vset_kind != NOT_CFG) begin
            e.result = vl;
            e.vtype  = vt;
        end else begin
            e.result = ref_alu(alu_op, a_sel, b_sel, rs1v, rs2v, pc, imm_i, imm_s, imm_u);
        end
        in_valid = 1'b1;
        // in_ready is settled at the falling edge
        @(negedge CLK);
        while (!in_ready) begin
            @(negedge CLK);
        end
        exp_q.push_back(e);
        issued++;
        @(posedge CLK);
        #1;
        in_valid = 1'b0;
    endtask

    // issue one multiply and count edges until its result shows
    task automatic run_mul_timed();
        int edges;
        edges = 0;
        send_op();
        @(negedge CLK);
        while (!out_valid) begin
            check_value("in_ready during multiply", cmp_t'(in_ready), cmp_t'(0));
            @(posedge CLK);
            edges++;
            @(negedge CLK);
        end
        check_value("multiply latency in edges", cmp_t'(edges), cmp_t'(MUL_CYCLES + 1));
        @(posedge CLK);
        #1;
    endtask

    // scoreboard, results leave in issue order
    always @(negedge CLK) begin
        if (nRST) begin
            if (held_valid) begin
                check_value("out_valid under back-pressure", cmp_t'(out_valid), cmp_t'(1));
                check_value("payload under back-pressure", out_payload, held_payload);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: a result came out with no op outstanding", $time);
                    errors++;
                end else begin
                    cur_exp = exp_q.pop_front();
                    results_seen++;
                    check_value("out_rd", cmp_t'(out_rd), cmp_t'(cur_exp.rd));
                    check_value("out_reg_write", cmp_t'(out_reg_write),
                                cmp_t'(cur_exp.reg_write));
                    check_value("out_result", cmp_t'(out_result), cmp_t'(cur_exp.result));
                    check_value("out_brj_addr", cmp_t'(out_brj_addr), cmp_t'(cur_exp.brj_addr));
                    check_value("out_branch_taken", cmp_t'(out_branch_taken),
                                cmp_t'(cur_exp.taken));
                    check_value("out_vtype", cmp_t'(out_vtype), cmp_t'(cur_exp.vtype));
                end
            end
            held_valid   = out_valid && !out_ready;
            held_payload = out_payload;
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int         i;
        int         k;
        int         pick;
        vset_kind_t kind;
        word_t      vt;
        nRST      = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        wb_en     = 1'b0;
        wb_rd     = '0;
        wb_data   = '0;
        base_payload();
        for (i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // idle state before the first issue
        @(negedge CLK);
        check_value("out_valid after reset", cmp_t'(out_valid), cmp_t'(0));
        check_value("in_ready after reset", cmp_t'(in_ready), cmp_t'(1));
        @(posedge CLK);
        #1;

        // x0 gets a write too, it must still read zero
        for (i = 0; i < 32; i++) begin
            write_reg(5'(i), word_t'($random(seed)));
        end
        // small avl values in x1..x7
        for (i = 1; i < 8; i++) begin
            write_reg(5'(i), word_t'(i * 9));
        end

        for (i = 0; i < N_ALU; i++) begin
            make_alu_op(i == 0);
            send_op();
        end

        for (i = 0; i < N_BR; i++) begin
            make_branch_op();
            send_op();
        end

        for (i = 0; i < N_MUL; i++) begin
            make_mul_op();
            run_mul_timed();
        end

        // every sew and lmul code, kinds taken in turn
        for (k = 0; k < 64; k++) begin
            kind = vset_kind_t'(2'(k % 3 + 1));
            vt   = {24'b0, 2'(k), 3'(k >> 3), 3'(k)};
            make_vset_op(kind, 5'(1 + k % 7), vt);
            send_op();
        end
        // reserved bit in the immediate
        make_vset_op(VSETVLI, 5'd3, 32'h0000_0108);
        send_op();
        // vill bit set in rs2
        make_vset_op(VSETVL, 5'd3, 32'h8000_0010);
        send_op();
        // rs1 = x0 asks for vlmax
        make_vset_op(VSETVLI, 5'd0, 32'h0000_0003);
        send_op();
        make_vset_op(VSETVL, 5'd0, 32'h0000_0011);
        send_op();

        // mixed ops under random out_ready
        rand_ready = 1'b1;
        for (i = 0; i < N_RAND; i++) begin
            pick = int'($unsigned($random(seed)) % 4);
            case (pick)
                0: make_alu_op(1'b0);
                1: make_branch_op();
                2: make_mul_op();
                default: begin
                    kind = vset_kind_t'(2'(1 + $unsigned($random(seed)) % 3));
                    vt   = {24'b0, 8'($random(seed))};
                    make_vset_op(kind, 5'(1 + i % 7), vt);
                end
            endcase
            send_op();
        end
        rand_ready = 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);

        if (issued != results_seen) begin
            $display("Error: %0d ops were issued but %0d results came out", issued, results_seen);
            errors++;
        end
        $display("errors %0d, results %0d of %0d issued", errors, results_seen, issued);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
src/ex_types_pkg.sv
src/vcfg_pkg.sv
src/scalar_reg_file.sv
src/operand_alu.sv
src/branch_jump_unit.sv
src/iter_multiplier.sv
src/vsetvl_unit.sv
src/execute_stage.sv
tb/ex_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module ex_tb -Mdir obj_dir

./obj_dir/Vex_tb 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
